// File: Makefile
SIM  := obj_dir/Vperiph_subsys_tb
SRCS := $(filter-out +%,$(shell cat all.f)) logic/periph_cfg.svh

.PHONY: all run clean

all: run

$(SIM): all.f $(SRCS)
	verilator --binary --timing --assert -j 0 --top-module periph_subsys_tb \
		-f all.f -o Vperiph_subsys_tb

run: $(SIM)
	./$(SIM) +verilator+error+limit+100 | tee sim.log
	grep -q "TESTBENCH PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

// File: all.f
+incdir+logic
logic/periph_pkg.sv
logic/timer.sv
logic/bus_decoder.sv
logic/irq_ctrl.sv
logic/periph_subsys.sv
dv/periph_subsys_sva.sv
dv/periph_subsys_tb.sv

// File: dv/periph_subsys_sva.sv
`timescale 1ns/1ns
`include "periph_cfg.svh"

module periph_subsys_sva
    import periph_pkg::*;
(
    input logic                   clk,
    input logic                   reset,
    input bus_req_t               req,
    input bus_rsp_t               rsp,
    input logic [`NUM_TIMERS-1:0] timer_irq,
    input logic [`NUM_TIMERS-1:0] mask,
    input logic                   irq_out
);

    int error_count = 0;

    rdy_high_in_reset: assert property (@(posedge clk) reset |=> rsp.rdy_n)
        else begin
            $error("rdy_n was low during or right after reset");
            error_count++;
        end

    // every slave and the unmapped hole answer one cycle after the strobe.
    rdy_after_strobe: assert property (@(posedge clk) disable iff (reset)
        !req.as_n |=> !rsp.rdy_n)
        else begin
            $error("rdy_n did not go low one cycle after a sampled strobe");
            error_count++;
        end

    rdy_idle: assert property (@(posedge clk) disable iff (reset)
        req.as_n |=> rsp.rdy_n)
        else begin
            $error("rdy_n was low one cycle after the strobe was high");
            error_count++;
        end

    irq_out_combined: assert property (@(posedge clk) disable iff (reset)
        1'b1 |=> (irq_out == $past(|(timer_irq & mask))))
        else begin
            $error("irq_out does not match the masked timer levels of the cycle before");
            error_count++;
        end

endmodule

bind periph_subsys periph_subsys_sva u_sva (
    .clk       (clk),
    .reset     (reset),
    .req       (req),
    .rsp       (rsp),
    .timer_irq (timer_irq),
    .mask      (u_irq_ctrl.mask),
    .irq_out   (irq_out)
);

// File: dv/periph_subsys_tb.sv
`timescale 1ns/1ns
`include "periph_cfg.svh"

module periph_subsys_tb
    import periph_pkg::*;
();

    localparam int SEL_W       = `BUS_ADDR_W - `REG_ADDR_W;
    localparam int BUS_TIMEOUT = 16;  // cycles a slave may take before the access counts as lost.
    localparam int IRQ_TIMEOUT = 64;

    logic     clk;
    logic     reset;
    bus_req_t req;
    bus_rsp_t rsp;
    logic     irq_out;

    string       current_test;
    int          errors;
    int          test_errors;
    int          tests_run;
    int          tests_failed;
    logic [15:0] lfsr_state;

    periph_subsys u_dut (
        .clk     (clk),
        .reset   (reset),
        .req     (req),
        .rsp     (rsp),
        .irq_out (irq_out)
    );

    initial clk = 1'b0;
    always #20 clk = ~clk;

    function automatic logic [`BUS_ADDR_W-1:0] reg_addr(input int slave,
                                                        input logic [`REG_ADDR_W-1:0] offset);
        return {SEL_W'(slave), offset};
    endfunction

    function automatic logic [`WORD_DATA_W-1:0] ctrl_word(input logic mode, input logic start);
        logic [`WORD_DATA_W-1:0] word;
        word = '0;
        word[`TIMER_MODE_LOC]  = mode;
        word[`TIMER_START_LOC] = start;
        return word;
    endfunction

    // x^16 + x^14 + x^13 + x^11 + 1.
    function automatic logic [15:0] lfsr_next(input logic [15:0] state);
        return {state[14:0], state[15] ^ state[13] ^ state[12] ^ state[10]};
    endfunction

    task automatic random_bits(input int nbits, output logic [31:0] value);
        value = '0;
        for (int i = 0; i < nbits; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            value = {value[30:0], lfsr_state[0]};
        end
    endtask

    task automatic note_failure();
        errors++;
        test_errors++;
    endtask

    task automatic begin_test(input string name);
        current_test = name;
        test_errors = 0;
    endtask

    task automatic end_test();
        tests_run++;
        if (test_errors == 0) begin
            $display("test %s: ok", current_test);
        end else begin
            tests_failed++;
            $display("test %s: %0d errors", current_test, test_errors);
        end
    endtask

    task automatic check_value(input string what, input logic [31:0] expected,
                               input logic [31:0] actual);
        assert (actual === expected) else begin
            $display("ERROR %s %s expected %h actual %h", current_test, what, expected, actual);
            note_failure();
        end
    endtask

    task automatic check_at_most(input string what, input logic [31:0] limit,
                                 input logic [31:0] actual);
        assert (actual <= limit) else begin
            $display("ERROR %s %s expected at most %0d actual %0d",
                     current_test, what, limit, actual);
            note_failure();
        end
    endtask

    // one strobed access whose inputs change only on the falling edge.
    task automatic bus_access(input logic rw, input logic [`BUS_ADDR_W-1:0] addr,
                              input logic [31:0] wr_data, output logic [31:0] rd_data);
        int   cycles;
        logic done;
        @(negedge clk);
        req.as_n    = 1'b0;
        req.rw      = rw;
        req.addr    = addr;
        req.wr_data = wr_data;
        done    = 1'b0;
        cycles  = 0;
        rd_data = '0;
        while (!done && cycles < BUS_TIMEOUT) begin
            @(negedge clk);
            cycles++;
            if (!rsp.rdy_n) begin
                done = 1'b1;
                rd_data = rsp.rd_data;
            end
        end
        if (!done) begin
            $display("bus access to address %h in test %s never saw rdy_n go low",
                     addr, current_test);
            note_failure();
        end
        req.as_n = 1'b1;
    endtask

    task automatic bus_write(input logic [`BUS_ADDR_W-1:0] addr, input logic [31:0] data);
        logic [31:0] unused;
        bus_access(`BUS_WRITE, addr, data, unused);
    endtask

    task automatic bus_read(input logic [`BUS_ADDR_W-1:0] addr, output logic [31:0] data);
        bus_access(`BUS_READ, addr, '0, data);
    endtask

    task automatic wait_timer_irq(input int slave);
        logic [31:0] value;
        int          reads;
        value = '0;
        reads = 0;
        while (value[`TIMER_IRQ_LOC] !== 1'b1 && reads < IRQ_TIMEOUT) begin
            bus_read(reg_addr(slave, TIMER_INTR), value);
            reads++;
        end
        if (value[`TIMER_IRQ_LOC] !== 1'b1) begin
            $display("timer %0d interrupt never rose in test %s", slave, current_test);
            note_failure();
        end
    endtask

    task automatic wait_irq_out(input logic level);
        int cycles;
        cycles = 0;
        while (irq_out !== level && cycles < IRQ_TIMEOUT) begin
            @(negedge clk);
            cycles++;
        end
        if (irq_out !== level) begin
            $display("irq_out never reached %b in test %s", level, current_test);
            note_failure();
        end
    endtask

    task automatic start_timer(input int slave, input logic [31:0] compare, input logic mode);
        bus_write(reg_addr(slave, TIMER_COUNTER), 32'd0);
        bus_write(reg_addr(slave, TIMER_INTR), 32'd0);
        bus_write(reg_addr(slave, TIMER_EXPR), compare);
        bus_write(reg_addr(slave, TIMER_CTRL), ctrl_word(mode, 1'b1));
    endtask

    task automatic test_readback();
        logic [31:0] wr_val;
        logic [31:0] rd_val;
        int          slave;
        begin_test("readback");
        for (int t = 0; t < `NUM_TIMERS; t++) begin
            slave = (t == 0) ? `SLAVE_TIMER0 : `SLAVE_TIMER1;
            random_bits(32, wr_val);
            bus_write(reg_addr(slave, TIMER_EXPR), wr_val);
            bus_read(reg_addr(slave, TIMER_EXPR), rd_val);
            check_value("compare", wr_val, rd_val);
            random_bits(32, wr_val);
            bus_write(reg_addr(slave, TIMER_COUNTER), wr_val);
            bus_read(reg_addr(slave, TIMER_COUNTER), rd_val);
            check_value("counter", wr_val, rd_val);
            random_bits(32, wr_val);
            wr_val[`TIMER_START_LOC] = 1'b0;
            bus_write(reg_addr(slave, TIMER_CTRL), wr_val);
            bus_read(reg_addr(slave, TIMER_CTRL), rd_val);
            check_value("control", ctrl_word(wr_val[`TIMER_MODE_LOC], 1'b0), rd_val);
            bus_write(reg_addr(slave, TIMER_CTRL), ctrl_word(PERIODIC, 1'b1));
            bus_read(reg_addr(slave, TIMER_CTRL), rd_val);
            check_value("control running", ctrl_word(PERIODIC, 1'b1), rd_val);
            bus_write(reg_addr(slave, TIMER_CTRL), ctrl_word(ONE_SHOT, 1'b0));
            bus_write(reg_addr(slave, TIMER_COUNTER), 32'd0);
        end
        random_bits(32, wr_val);
        bus_write(reg_addr(`SLAVE_IRQ, IRQ_MASK), wr_val);
        bus_read(reg_addr(`SLAVE_IRQ, IRQ_MASK), rd_val);
        check_value("mask", 32'(wr_val[`NUM_TIMERS-1:0]), rd_val);  // only one bit per timer.
        bus_write(reg_addr(`SLAVE_IRQ, IRQ_MASK), 32'd0);
        random_bits(32, wr_val);
        bus_write(reg_addr(`SLAVE_UNMAPPED, wr_val[1:0]), wr_val);
        bus_read(reg_addr(`SLAVE_UNMAPPED, wr_val[3:2]), rd_val);
        check_value("unmapped read", 32'd0, rd_val);
        end_test();
    endtask

    task automatic test_one_shot();
        logic [31:0] compare;
        logic [31:0] rd_val;
        begin_test("one_shot");
        random_bits(4, compare);
        compare = compare + 32'd5;
        start_timer(`SLAVE_TIMER0, compare, ONE_SHOT);
        wait_timer_irq(`SLAVE_TIMER0);
        bus_read(reg_addr(`SLAVE_TIMER0, TIMER_CTRL), rd_val);
        check_value("control after match", ctrl_word(ONE_SHOT, 1'b0), rd_val);
        for (int i = 0; i < 2; i++) begin
            bus_read(reg_addr(`SLAVE_TIMER0, TIMER_COUNTER), rd_val);
            check_value("stopped counter", 32'd0, rd_val);
        end
        bus_write(reg_addr(`SLAVE_TIMER0, TIMER_INTR), 32'd0);
        end_test();
    endtask

    task automatic test_periodic();
        logic [31:0] compare;
        logic [31:0] rd_val;
        begin_test("periodic");
        random_bits(3, compare);
        compare = compare + 32'd8;  // long enough that a clear is read back before the next match.
        start_timer(`SLAVE_TIMER1, compare, PERIODIC);
        for (int i = 0; i < 8; i++) begin
            bus_read(reg_addr(`SLAVE_TIMER1, TIMER_COUNTER), rd_val);
            check_at_most("counter", compare, rd_val);
        end
        wait_timer_irq(`SLAVE_TIMER1);
        bus_write(reg_addr(`SLAVE_TIMER1, TIMER_INTR), 32'd0);
        bus_read(reg_addr(`SLAVE_TIMER1, TIMER_INTR), rd_val);
        check_value("interrupt after clear", 32'd0, rd_val);
        wait_timer_irq(`SLAVE_TIMER1);
        bus_read(reg_addr(`SLAVE_TIMER1, TIMER_CTRL), rd_val);
        check_value("control", ctrl_word(PERIODIC, 1'b1), rd_val);
        bus_write(reg_addr(`SLAVE_TIMER1, TIMER_CTRL), ctrl_word(ONE_SHOT, 1'b0));
        bus_write(reg_addr(`SLAVE_TIMER1, TIMER_INTR), 32'd0);
        end_test();
    endtask

    task automatic test_irq_mask();
        logic [31:0] rd_val;
        begin_test("irq_mask");
        bus_write(reg_addr(`SLAVE_IRQ, IRQ_MASK), 32'h2);  // timer 1 only.
        start_timer(`SLAVE_TIMER0, 32'd8, ONE_SHOT);
        wait_timer_irq(`SLAVE_TIMER0);
        @(negedge clk);
        check_value("irq_out masked", 32'd0, 32'(irq_out));
        bus_read(reg_addr(`SLAVE_IRQ, IRQ_STATUS), rd_val);
        check_value("status masked", 32'd0, rd_val);
        bus_write(reg_addr(`SLAVE_TIMER0, TIMER_INTR), 32'd0);
        start_timer(`SLAVE_TIMER1, 32'd8, ONE_SHOT);
        wait_irq_out(1'b1);
        bus_read(reg_addr(`SLAVE_IRQ, IRQ_STATUS), rd_val);
        check_value("status", 32'h2, rd_val);
        end_test();
    endtask

    task automatic test_clear_overwrite();
        logic [31:0] value;
        logic [31:0] rd_val;
        begin_test("clear_overwrite");
        bus_write(reg_addr(`SLAVE_TIMER1, TIMER_INTR), 32'd0);
        @(negedge clk);
        check_value("irq_out after clear", 32'd0, 32'(irq_out));
        bus_read(reg_addr(`SLAVE_TIMER1, TIMER_INTR), rd_val);
        check_value("interrupt after clear", 32'd0, rd_val);
        start_timer(`SLAVE_TIMER0, 32'hffff_ff00, PERIODIC);
        random_bits(8, value);
        value = value + 32'h1000;
        bus_write(reg_addr(`SLAVE_TIMER0, TIMER_COUNTER), value);
        // reads are sampled two and four cycles after the write.
        bus_read(reg_addr(`SLAVE_TIMER0, TIMER_COUNTER), rd_val);
        check_value("counter after write", value + 32'd1, rd_val);
        bus_read(reg_addr(`SLAVE_TIMER0, TIMER_COUNTER), rd_val);
        check_value("counter still running", value + 32'd3, rd_val);
        bus_write(reg_addr(`SLAVE_TIMER0, TIMER_CTRL), ctrl_word(ONE_SHOT, 1'b0));
        end_test();
    endtask

    task automatic test_random_access();
        logic [31:0] sel;
        logic [31:0] offset;
        logic [31:0] rw;
        logic [31:0] data;
        logic [31:0] rd_val;
        begin_test("random_access");
        bus_write(reg_addr(`SLAVE_IRQ, IRQ_MASK), 32'h3);
        for (int i = 0; i < 48; i++) begin
            random_bits(2, sel);
            random_bits(2, offset);
            random_bits(1, rw);
            random_bits(32, data);
            if (rw[0] == `BUS_READ) begin
                bus_read(reg_addr(int'(sel[1:0]), offset[1:0]), rd_val);
                if (sel[1:0] == 2'(`SLAVE_UNMAPPED)) begin
                    check_value("unmapped read", 32'd0, rd_val);
                end
            end else begin
                bus_write(reg_addr(int'(sel[1:0]), offset[1:0]), data);
            end
        end
        end_test();
    endtask

    initial begin
        int sva_errors;
        errors       = 0;
        test_errors  = 0;
        tests_run    = 0;
        tests_failed = 0;
        lfsr_state   = 16'd75;
        current_test = "reset";
        req          = '0;
        req.as_n     = 1'b1;
        req.rw       = `BUS_READ;
        reset        = 1'b1;
        repeat (8) @(negedge clk);
        reset = 1'b0;
        test_readback();
        test_one_shot();
        test_periodic();
        test_irq_mask();
        test_clear_overwrite();
        test_random_access();
        sva_errors = u_dut.u_sva.error_count;
        $display("tests run %0d, tests with errors %0d, check errors %0d, assertion errors %0d",
                 tests_run, tests_failed, errors, sva_errors);
        if (errors == 0 && sva_errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

// File: logic/bus_decoder.sv
`timescale 1ns/1ns
`include "periph_cfg.svh"

module bus_decoder
    import periph_pkg::*;
(
    input  logic                   clk,
    input  logic                   reset,
    input  bus_req_t               req,
    output logic [`NUM_SLAVES-1:0] cs_n,
    input  bus_rsp_t               slave_rsp [`NUM_SLAVES],
    output bus_rsp_t               rsp
);

    localparam int SEL_W = `BUS_ADDR_W - `REG_ADDR_W;

    logic [SEL_W-1:0] slave_sel;
    logic             unmap_rdy_n;

    assign slave_sel = req.addr[`BUS_ADDR_W-1:`REG_ADDR_W];

    always_comb begin
        for (int i = 0; i < `NUM_SLAVES; i++) begin
            cs_n[i] = !(!req.as_n && (slave_sel == SEL_W'(i)));
        end
    end

    // accesses to the hole in the map still complete, with zero data.
    always_ff @(posedge clk) begin
        if (reset) begin
            unmap_rdy_n <= 1'b1;
        end else begin
            unmap_rdy_n <= !(!req.as_n && (slave_sel == SEL_W'(`SLAVE_UNMAPPED)));
        end
    end

    always_comb begin
        rsp.rd_data = '0;  // the unmapped hole adds no data.
        rsp.rdy_n   = unmap_rdy_n;
        for (int i = 0; i < `NUM_SLAVES; i++) begin
            rsp.rd_data = rsp.rd_data | slave_rsp[i].rd_data;  // idle slaves drive zero.
            rsp.rdy_n   = rsp.rdy_n & slave_rsp[i].rdy_n;
        end
    end

endmodule

// File: logic/irq_ctrl.sv
`timescale 1ns/1ns
`include "periph_cfg.svh"

module irq_ctrl
    import periph_pkg::*;
(
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   cs_n,
    input  bus_req_t               req,
    input  logic [`NUM_TIMERS-1:0] timer_irq,
    output bus_rsp_t               rsp,
    output logic                   irq_out
);

    logic [`NUM_TIMERS-1:0]  mask;
    logic [`NUM_TIMERS-1:0]  status;
    logic [`WORD_DATA_W-1:0] rd_data;
    logic                    rdy_n;
    logic                    access;
    logic                    rd_en;
    logic                    wr_en;
    irq_reg_e                reg_sel;

    assign access  = !cs_n && !req.as_n;
    assign rd_en   = access && (req.rw == `BUS_READ);
    assign wr_en   = access && (req.rw == `BUS_WRITE);
    assign reg_sel = irq_reg_e'(req.addr[`REG_ADDR_W-1:0]);

    assign status = timer_irq & mask;  // timer levels pass through unlatched.

    assign rsp.rd_data = rd_data;
    assign rsp.rdy_n   = rdy_n;

    always_ff @(posedge clk) begin
        if (reset) begin
            rdy_n <= 1'b1;
        end else begin
            rdy_n <= !access;
        end
    end

    always_ff @(posedge clk) begin
        if (rd_en) begin
            case (reg_sel)
                IRQ_MASK:   rd_data <= `WORD_DATA_W'(mask);
                IRQ_STATUS: rd_data <= `WORD_DATA_W'(status);
                default:    rd_data <= '0;  // offsets 2 and 3 read as zero.
            endcase
        end else begin
            rd_data <= '0;
        end
    end

    // Status is read only, so only the mask takes writes.
    always_ff @(posedge clk) begin
        if (reset) begin
            mask <= '0;
        end else if (wr_en && (reg_sel == IRQ_MASK)) begin
            mask <= req.wr_data[`NUM_TIMERS-1:0];
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            irq_out <= 1'b0;
        end else begin
            irq_out <= |status;  // one cycle behind the levels and the mask.
        end
    end

endmodule

// File: logic/periph_cfg.svh
`ifndef PERIPH_CFG_SVH
`define PERIPH_CFG_SVH

// bus widths.
`define WORD_DATA_W      32
`define BUS_ADDR_W       4  // upper bits pick the slave, lower bits the register.
`define REG_ADDR_W       2

// bus direction encoding on rw.
`define BUS_READ         1'b1
`define BUS_WRITE        1'b0

// slave map on the upper address bits.
`define SLAVE_TIMER0     0
`define SLAVE_TIMER1     1
`define SLAVE_IRQ        2
`define SLAVE_UNMAPPED   3  // nothing lives here and the decoder answers itself.
`define NUM_SLAVES       3

`define NUM_TIMERS       2

// bit locations inside the timer control and interrupt words.
`define TIMER_START_LOC  0
`define TIMER_MODE_LOC   1
`define TIMER_IRQ_LOC    0

`endif

// File: logic/periph_pkg.sv
`include "periph_cfg.svh"

package periph_pkg;

    // as_n in the request and rdy_n in the response are active low.
    typedef struct packed {
        logic                    as_n;
        logic                    rw;       // read is 1.
        logic [`BUS_ADDR_W-1:0]  addr;
        logic [`WORD_DATA_W-1:0] wr_data;
    } bus_req_t;

    typedef struct packed {
        logic [`WORD_DATA_W-1:0] rd_data;
        logic                    rdy_n;
    } bus_rsp_t;

    typedef enum logic [`REG_ADDR_W-1:0] {
        TIMER_CTRL    = 2'd0,
        TIMER_INTR    = 2'd1,
        TIMER_EXPR    = 2'd2,
        TIMER_COUNTER = 2'd3
    } timer_reg_e;

    typedef enum logic [`REG_ADDR_W-1:0] {
        IRQ_MASK   = 2'd0,
        IRQ_STATUS = 2'd1
    } irq_reg_e;

    typedef enum logic {
        ONE_SHOT = 1'b0,
        PERIODIC = 1'b1
    } timer_mode_e;

    // field order matches the control word layout.
    typedef struct packed {
        timer_mode_e mode;   // bit 1.
        logic        start;  // bit 0.
    } timer_ctrl_t;

endpackage

// File: logic/periph_subsys.sv
`timescale 1ns/1ns
`include "periph_cfg.svh"

module periph_subsys
    import periph_pkg::*;
(
    input  logic     clk,
    input  logic     reset,
    input  bus_req_t req,
    output bus_rsp_t rsp,
    output logic     irq_out
);

    logic [`NUM_SLAVES-1:0] cs_n;
    bus_rsp_t               slave_rsp [`NUM_SLAVES];
    logic [`NUM_TIMERS-1:0] timer_irq;

    bus_decoder u_bus_decoder (
        .clk       (clk),
        .reset     (reset),
        .req       (req),
        .cs_n      (cs_n),
        .slave_rsp (slave_rsp),
        .rsp       (rsp)
    );

    timer u_timer0 (
        .clk   (clk),
        .reset (reset),
        .cs_n  (cs_n[`SLAVE_TIMER0]),
        .req   (req),
        .rsp   (slave_rsp[`SLAVE_TIMER0]),
        .irq   (timer_irq[0])
    );

    timer u_timer1 (
        .clk   (clk),
        .reset (reset),
        .cs_n  (cs_n[`SLAVE_TIMER1]),
        .req   (req),
        .rsp   (slave_rsp[`SLAVE_TIMER1]),
        .irq   (timer_irq[1])
    );

    // masks both timer levels into the single host interrupt.
    irq_ctrl u_irq_ctrl (
        .clk       (clk),
        .reset     (reset),
        .cs_n      (cs_n[`SLAVE_IRQ]),
        .req       (req),
        .timer_irq (timer_irq),
        .rsp       (slave_rsp[`SLAVE_IRQ]),
        .irq_out   (irq_out)
    );

endmodule

// File: logic/timer.sv
`timescale 1ns/1ns
`include "periph_cfg.svh"

module timer
    import periph_pkg::*;
(
    input  logic     clk,
    input  logic     reset,
    input  logic     cs_n,
    input  bus_req_t req,
    output bus_rsp_t rsp,
    output logic     irq
);

    timer_ctrl_t             ctrl;
    logic [`WORD_DATA_W-1:0] expr_val;
    logic [`WORD_DATA_W-1:0] counter;
    logic [`WORD_DATA_W-1:0] rd_data;
    logic                    rdy_n;
    logic                    access;
    logic                    rd_en;
    logic                    wr_en;
    logic                    match;
    timer_reg_e              reg_sel;

    assign access  = !cs_n && !req.as_n;  // selected and strobed.
    assign rd_en   = access && (req.rw == `BUS_READ);
    assign wr_en   = access && (req.rw == `BUS_WRITE);
    assign reg_sel = timer_reg_e'(req.addr[`REG_ADDR_W-1:0]);

    // the compare only counts while the timer runs.
    assign match = ctrl.start && (counter == expr_val);

    assign rsp.rd_data = rd_data;
    assign rsp.rdy_n   = rdy_n;

    always_ff @(posedge clk) begin
        if (reset) begin
            rdy_n <= 1'b1;
        end else begin
            rdy_n <= !access;  // one cycle after the sampled strobe.
        end
    end

    always_ff @(posedge clk) begin
        if (rd_en) begin
            case (reg_sel)
                TIMER_CTRL:    rd_data <= `WORD_DATA_W'(ctrl);
                TIMER_INTR:    rd_data <= `WORD_DATA_W'(irq);
                TIMER_EXPR:    rd_data <= expr_val;
                TIMER_COUNTER: rd_data <= counter;
            endcase
        end else begin
            rd_data <= '0;  // idle slaves must not disturb the OR in the decoder.
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            ctrl <= '{mode: ONE_SHOT, start: 1'b0};
        end else if (wr_en && (reg_sel == TIMER_CTRL)) begin
            ctrl.start <= req.wr_data[`TIMER_START_LOC];
            ctrl.mode  <= timer_mode_e'(req.wr_data[`TIMER_MODE_LOC]);
        end else if (match && (ctrl.mode == ONE_SHOT)) begin
            ctrl.start <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            irq <= 1'b0;
        end else if (match) begin
            irq <= 1'b1;  // a match wins over a software clear.
        end else if (wr_en && (reg_sel == TIMER_INTR)) begin
            irq <= req.wr_data[`TIMER_IRQ_LOC];
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            expr_val <= '0;
        end else if (wr_en && (reg_sel == TIMER_EXPR)) begin
            expr_val <= req.wr_data;
        end
    end

    // Host writes override both the wrap and the increment.
    always_ff @(posedge clk) begin
        if (reset) begin
            counter <= '0;
        end else if (wr_en && (reg_sel == TIMER_COUNTER)) begin
            counter <= req.wr_data;
        end else if (match) begin
            counter <= '0;
        end else if (ctrl.start) begin
            counter <= counter + `WORD_DATA_W'(1);
        end
    end

endmodule
